// ==== Bender.yml ====
package:
  name: avmm2_transfer

sources:
  - rtl/avmm2_cmd_pkg.sv
  - rtl/avmm2_rsp_pkg.sv
  - rtl/avmm2_cfg.sv
  - rtl/avmm2_cmd_framer.sv
  - rtl/avmm2_cmd_fifo.sv
  - rtl/avmm2_cmd_serializer.sv
  - rtl/avmm2_rsp_deserializer.sv
  - rtl/avmm2_rsp_decoder.sv
  - rtl/avmm2_transfer.sv
  - target: test
    files:
      - test/avmm2_transfer_checker.sv
      - test/avmm2_transfer_tb.sv

// ==== rtl/avmm2_cfg.sv ====
/* AVMM2 configuration
   Synchronizes user mode and hssi busy, opens the command gate, picks busy source */
module avmm2_cfg
(
	input  logic avmm_clock_avmm_clk,
	input  logic avmm_reset_avmm_rst_n,
	input  logic usermode_in,
	input  logic r_avmm2_gate_dis,
	input  logic sr_hssi_avmm_busy,
	output logic cmd_gate_open,
	output logic hssi_busy_sync,
	output logic busy_from_hssi
);

	// Bit 1 is hssi busy, bit 0 is user mode
	logic [1:0] sync_meta;
	logic [1:0] sync_out;

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			sync_meta      <= 2'b10;	// Busy resets high, user mode low
			sync_out       <= 2'b10;
			busy_from_hssi <= 1'b1;
		end
		else
		begin
			sync_meta <= {sr_hssi_avmm_busy, usermode_in};
			sync_out  <= sync_meta;
			if (busy_from_hssi)
			begin
				busy_from_hssi <= sync_out[1];	// Sticky once cleared
			end
		end
	end

	assign hssi_busy_sync = sync_out[1];
	assign cmd_gate_open  = r_avmm2_gate_dis | sync_out[0];

endmodule

// ==== rtl/avmm2_cmd_fifo.sv ====
/* AVMM2 command queue
   Synchronous frame FIFO with full and partial-full flags, forced high on freeze */
module avmm2_cmd_fifo
#(
	parameter int CMD_FIFO_DEPTH  = 16,
	parameter int CMD_PFULL_LEVEL = 12
)
(
	input  logic                      avmm_clock_avmm_clk,
	input  logic                      avmm_reset_avmm_rst_n,
	input  logic                      cmd_push,
	input  avmm2_cmd_pkg::cmd_frame_t cmd_frame,
	input  logic                      cmd_pop,
	input  logic                      nfrzdrv_in,
	output avmm2_cmd_pkg::cmd_frame_t fifo_head,
	output logic                      fifo_empty,
	output logic                      pld_avmm_cmdfifo_wr_full,
	output logic                      pld_avmm_cmdfifo_wr_pfull
);

	localparam int PTR_W = (CMD_FIFO_DEPTH > 1) ? $clog2(CMD_FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_FIFO_DEPTH + 1);

	avmm2_cmd_pkg::cmd_frame_t mem [CMD_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             push_ok;
	logic             pop_ok;

	assign full       = count == CNT_W'(CMD_FIFO_DEPTH);
	assign fifo_empty = count == '0;
	assign push_ok    = cmd_push & ~full;	// Dropped when full
	assign pop_ok     = cmd_pop & ~fifo_empty;
	assign fifo_head  = mem[rd_ptr];

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= cmd_frame;
	end

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= (wr_ptr == PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
		end
	end

	assign pld_avmm_cmdfifo_wr_full  = nfrzdrv_in ? full : 1'b1;
	assign pld_avmm_cmdfifo_wr_pfull = nfrzdrv_in ? (count >= CNT_W'(CMD_PFULL_LEVEL)) : 1'b1;

endmodule

// ==== rtl/avmm2_cmd_framer.sv ====
/* AVMM2 command framer
   Gates fabric commands and builds parity-protected frames for the queue */
module avmm2_cmd_framer
(
	input  logic                             avmm_clock_avmm_clk,
	input  logic                             avmm_reset_avmm_rst_n,
	input  logic                             cmd_gate_open,
	input  logic                             pld_avmm_read,
	input  logic                             pld_avmm_write,
	input  logic                             pld_avmm_request,
	input  logic [avmm2_cmd_pkg::ADDR_W-1:0] pld_avmm_reg_addr,
	input  logic [avmm2_cmd_pkg::DATA_W-1:0] pld_avmm_writedata,
	output avmm2_cmd_pkg::cmd_frame_t        cmd_frame,
	output logic                             cmd_push
);

	logic read_g;
	logic write_g;
	logic request_g;
	logic request_q;
	logic request_chg;

	assign read_g    = cmd_gate_open & pld_avmm_read;
	assign write_g   = cmd_gate_open & pld_avmm_write;
	assign request_g = cmd_gate_open & pld_avmm_request;

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
			request_q <= 1'b0;
		else
			request_q <= request_g;
	end

	assign request_chg = request_q != request_g;	// Request toggle alone also sends
	assign cmd_push    = read_g | write_g | request_chg;

	always_comb
	begin
		cmd_frame         = '0;
		cmd_frame.valid   = cmd_push;
		cmd_frame.write   = write_g;
		cmd_frame.request = request_g;
		cmd_frame.read    = read_g;
		cmd_frame.addr    = pld_avmm_reg_addr;
		cmd_frame.wdata   = pld_avmm_writedata;
		cmd_frame.parity  = ^cmd_frame;	// Parity field still zero here
	end

endmodule

// ==== rtl/avmm2_cmd_pkg.sv ====
/* AVMM2 command path definitions
   Frame layout and serializer states for the fabric-to-link direction */
package avmm2_cmd_pkg;

	localparam int ADDR_W      = 9;	// Fabric register address
	localparam int DATA_W      = 8;	// Write and read data
	localparam int CMD_FRAME_W = 32;

	// Command frame, bit 0 first on the link
	typedef struct packed {
		logic [DATA_W-1:0] wdata;	// Bits 31:24
		logic              parity;	// XOR of the other 31 bits
		logic [9:0]        rsvd;	// Always sent as zero
		logic [ADDR_W-1:0] addr;	// Bits 12:4
		logic              read;
		logic              request;	// Current request level
		logic              write;
		logic              valid;	// Bit 0
	} cmd_frame_t;

	typedef enum logic {
		SER_IDLE,
		SER_SEND
	} ser_state_e;

endpackage

// ==== rtl/avmm2_cmd_serializer.sv ====
/* AVMM2 command serializer
   Pops queued frames and sends them two bits per clock, lowest pair first */
module avmm2_cmd_serializer
(
	input  logic                      avmm_clock_avmm_clk,
	input  logic                      avmm_reset_avmm_rst_n,
	input  logic                      fifo_empty,
	input  avmm2_cmd_pkg::cmd_frame_t fifo_head,
	output logic                      cmd_pop,
	output logic [1:0]                aib_fabric_avmm_data_out
);

	localparam int BEATS  = avmm2_cmd_pkg::CMD_FRAME_W / 2;
	localparam int BEAT_W = $clog2(BEATS);

	avmm2_cmd_pkg::ser_state_e         state;
	logic [BEAT_W-1:0]                 beat;	// Pair now on the link
	logic [avmm2_cmd_pkg::CMD_FRAME_W-1:0] shift;
	logic                              last_beat;

	assign last_beat = (state == avmm2_cmd_pkg::SER_SEND) && (beat == BEAT_W'(BEATS - 1));
	assign cmd_pop   = ~fifo_empty & ((state == avmm2_cmd_pkg::SER_IDLE) | last_beat);

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			state                    <= avmm2_cmd_pkg::SER_IDLE;
			beat                     <= '0;
			aib_fabric_avmm_data_out <= 2'b00;
		end
		else if (cmd_pop)
		begin
			state                    <= avmm2_cmd_pkg::SER_SEND;
			beat                     <= '0;
			aib_fabric_avmm_data_out <= fifo_head[1:0];	// Pair 0 goes out at once
		end
		else if (last_beat)
		begin
			state                    <= avmm2_cmd_pkg::SER_IDLE;
			aib_fabric_avmm_data_out <= 2'b00;
		end
		else if (state == avmm2_cmd_pkg::SER_SEND)
		begin
			beat                     <= beat + 1'b1;
			aib_fabric_avmm_data_out <= shift[1:0];
		end
	end

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (cmd_pop)
			shift <= fifo_head >> 2;
		else
			shift <= shift >> 2;
	end

endmodule

// ==== rtl/avmm2_rsp_decoder.sv ====
/* AVMM2 response decoder
   Checks response frames and drives busy, read data and the sticky error flag */
module avmm2_rsp_decoder
(
	input  logic                             avmm_clock_avmm_clk,
	input  logic                             avmm_reset_avmm_rst_n,
	input  avmm2_rsp_pkg::rsp_frame_t        rsp_frame,
	input  logic                             rsp_strobe,
	input  logic                             hssi_busy_sync,
	input  logic                             busy_from_hssi,
	input  logic                             nfrzdrv_in,
	output logic                             pld_avmm_busy,
	output logic [avmm2_cmd_pkg::DATA_W-1:0] pld_avmm_readdata,
	output logic                             pld_avmm_readdatavalid,
	output logic                             avmm_transfer_error
);

	logic                             busy_q;	// Busy bit of last frame
	logic [avmm2_cmd_pkg::DATA_W-1:0] rdata_q;
	logic                             rdv_q;
	logic                             parity_err;
	logic                             valid_err;
	logic                             data_ok;

	assign parity_err = ^rsp_frame;	// Whole frame XORs to zero when good
	assign valid_err  = rsp_frame.valid != rsp_frame.valid_copy;

	// Busy release and readdatavalid never come in the same frame
	assign data_ok = rsp_strobe & ~rsp_frame.busy & ~busy_q;

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			busy_q              <= 1'b0;
			rdv_q               <= 1'b0;
			rdata_q             <= '0;
			avmm_transfer_error <= 1'b0;
		end
		else
		begin
			if (rsp_strobe)
				busy_q <= rsp_frame.busy;
			if (rsp_strobe & (parity_err | valid_err))
				avmm_transfer_error <= 1'b1;	// Held until reset
			if (data_ok)
			begin
				rdv_q   <= rsp_frame.readdatavalid;
				rdata_q <= rsp_frame.rdata;
			end
			else
			begin
				rdv_q   <= 1'b0;
				rdata_q <= '0;
			end
		end
	end

	// Freeze forces all fabric outputs high
	assign pld_avmm_busy          = nfrzdrv_in ? (busy_from_hssi ? hssi_busy_sync : busy_q) : 1'b1;
	assign pld_avmm_readdata      = nfrzdrv_in ? rdata_q : '1;
	assign pld_avmm_readdatavalid = nfrzdrv_in ? rdv_q : 1'b1;

endmodule

// ==== rtl/avmm2_rsp_deserializer.sv ====
/* AVMM2 response deserializer
   Collects 16-bit response frames from the serial link, start bit first */
module avmm2_rsp_deserializer
(
	input  logic                      avmm_clock_avmm_clk,
	input  logic                      avmm_reset_avmm_rst_n,
	input  logic                      aib_fabric_avmm_data_in,
	output avmm2_rsp_pkg::rsp_frame_t rsp_frame,
	output logic                      rsp_strobe
);

	localparam int FW    = avmm2_rsp_pkg::RSP_FRAME_W;
	localparam int CNT_W = $clog2(FW);

	avmm2_rsp_pkg::des_state_e state;
	logic             data_in_q;
	logic [CNT_W-1:0] bit_cnt;	// Bits captured so far
	logic [FW-1:0]    shift;

	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		if (!avmm_reset_avmm_rst_n)
		begin
			data_in_q  <= 1'b0;
			state      <= avmm2_rsp_pkg::DES_IDLE;
			bit_cnt    <= '0;
			rsp_strobe <= 1'b0;
		end
		else
		begin
			data_in_q  <= aib_fabric_avmm_data_in;
			rsp_strobe <= 1'b0;
			if (state == avmm2_rsp_pkg::DES_IDLE)
			begin
				if (data_in_q)
				begin
					state   <= avmm2_rsp_pkg::DES_COLLECT;	// Start marker seen
					bit_cnt <= CNT_W'(1);
				end
			end
			else if (bit_cnt == CNT_W'(FW - 1))
			begin
				state      <= avmm2_rsp_pkg::DES_IDLE;
				bit_cnt    <= '0;
				rsp_strobe <= 1'b1;
			end
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// Shift right so the first bit ends up at bit 0
	always_ff @(posedge avmm_clock_avmm_clk)
	begin
		shift <= {data_in_q, shift[FW-1:1]};
		if ((state == avmm2_rsp_pkg::DES_COLLECT) && (bit_cnt == CNT_W'(FW - 1)))
			rsp_frame <= avmm2_rsp_pkg::rsp_frame_t'({data_in_q, shift[FW-1:1]});
	end

endmodule

// ==== rtl/avmm2_rsp_pkg.sv ====
/* AVMM2 response path definitions
   Frame layout and deserializer states for the link-to-fabric direction */
package avmm2_rsp_pkg;

	localparam int RSP_FRAME_W = 16;

	// Response frame, bit 0 arrives first and doubles as start marker
	typedef struct packed {
		logic                                valid_copy;	// Must equal valid
		logic                                parity;	// XOR of the other 15 bits
		logic [2:0]                          rsvd;
		logic                                readdatavalid;
		logic [avmm2_cmd_pkg::DATA_W-1:0]    rdata;	// Bits 9:2
		logic                                busy;
		logic                                valid;	// Always 1
	} rsp_frame_t;

	typedef enum logic {
		DES_IDLE,
		DES_COLLECT
	} des_state_e;

endpackage

// ==== rtl/avmm2_transfer.sv ====
/* AVMM2 transfer bridge top
   Fabric Avalon-MM commands out as 2-bit serial frames, 1-bit serial responses back */
module avmm2_transfer
#(
	parameter int CMD_FIFO_DEPTH  = 16,
	parameter int CMD_PFULL_LEVEL = 12
)
(
	input  logic                             avmm_clock_avmm_clk,
	input  logic                             avmm_reset_avmm_rst_n,
	input  logic                             aib_fabric_avmm_data_in,
	input  logic                             pld_avmm_read,
	input  logic [avmm2_cmd_pkg::ADDR_W-1:0] pld_avmm_reg_addr,
	input  logic                             pld_avmm_request,
	input  logic                             pld_avmm_write,
	input  logic [avmm2_cmd_pkg::DATA_W-1:0] pld_avmm_writedata,
	input  logic                             nfrzdrv_in,
	input  logic                             usermode_in,
	input  logic                             sr_hssi_avmm_busy,
	input  logic                             r_avmm2_gate_dis,
	output logic [1:0]                       aib_fabric_avmm_data_out,
	output logic                             pld_avmm_busy,
	output logic [avmm2_cmd_pkg::DATA_W-1:0] pld_avmm_readdata,
	output logic                             pld_avmm_readdatavalid,
	output logic                             pld_avmm_cmdfifo_wr_full,
	output logic                             pld_avmm_cmdfifo_wr_pfull,
	output logic                             avmm_transfer_error
);

	logic                      cmd_gate_open;
	logic                      hssi_busy_sync;
	logic                      busy_from_hssi;
	avmm2_cmd_pkg::cmd_frame_t cmd_frame;
	logic                      cmd_push;
	avmm2_cmd_pkg::cmd_frame_t fifo_head;
	logic                      fifo_empty;
	logic                      cmd_pop;
	avmm2_rsp_pkg::rsp_frame_t rsp_frame;
	logic                      rsp_strobe;

	avmm2_cfg u_cfg (
		.avmm_clock_avmm_clk   (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
		.usermode_in           (usermode_in),
		.r_avmm2_gate_dis      (r_avmm2_gate_dis),
		.sr_hssi_avmm_busy     (sr_hssi_avmm_busy),
		.cmd_gate_open         (cmd_gate_open),
		.hssi_busy_sync        (hssi_busy_sync),
		.busy_from_hssi        (busy_from_hssi)
	);

	avmm2_cmd_framer u_framer (
		.avmm_clock_avmm_clk   (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
		.cmd_gate_open         (cmd_gate_open),
		.pld_avmm_read         (pld_avmm_read),
		.pld_avmm_write        (pld_avmm_write),
		.pld_avmm_request      (pld_avmm_request),
		.pld_avmm_reg_addr     (pld_avmm_reg_addr),
		.pld_avmm_writedata    (pld_avmm_writedata),
		.cmd_frame             (cmd_frame),
		.cmd_push              (cmd_push)
	);

	avmm2_cmd_fifo #(
		.CMD_FIFO_DEPTH  (CMD_FIFO_DEPTH),
		.CMD_PFULL_LEVEL (CMD_PFULL_LEVEL)
	) u_cmd_fifo (
		.avmm_clock_avmm_clk       (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n     (avmm_reset_avmm_rst_n),
		.cmd_push                  (cmd_push),
		.cmd_frame                 (cmd_frame),
		.cmd_pop                   (cmd_pop),
		.nfrzdrv_in                (nfrzdrv_in),
		.fifo_head                 (fifo_head),
		.fifo_empty                (fifo_empty),
		.pld_avmm_cmdfifo_wr_full  (pld_avmm_cmdfifo_wr_full),
		.pld_avmm_cmdfifo_wr_pfull (pld_avmm_cmdfifo_wr_pfull)
	);

	avmm2_cmd_serializer u_serializer (
		.avmm_clock_avmm_clk      (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n    (avmm_reset_avmm_rst_n),
		.fifo_empty               (fifo_empty),
		.fifo_head                (fifo_head),
		.cmd_pop                  (cmd_pop),
		.aib_fabric_avmm_data_out (aib_fabric_avmm_data_out)
	);

	avmm2_rsp_deserializer u_deserializer (
		.avmm_clock_avmm_clk     (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n   (avmm_reset_avmm_rst_n),
		.aib_fabric_avmm_data_in (aib_fabric_avmm_data_in),
		.rsp_frame               (rsp_frame),
		.rsp_strobe              (rsp_strobe)
	);

	avmm2_rsp_decoder u_decoder (
		.avmm_clock_avmm_clk    (avmm_clock_avmm_clk),
		.avmm_reset_avmm_rst_n  (avmm_reset_avmm_rst_n),
		.rsp_frame              (rsp_frame),
		.rsp_strobe             (rsp_strobe),
		.hssi_busy_sync         (hssi_busy_sync),
		.busy_from_hssi         (busy_from_hssi),
		.nfrzdrv_in             (nfrzdrv_in),
		.pld_avmm_busy          (pld_avmm_busy),
		.pld_avmm_readdata      (pld_avmm_readdata),
		.pld_avmm_readdatavalid (pld_avmm_readdatavalid),
		.avmm_transfer_error    (avmm_transfer_error)
	);

endmodule

// ==== sources.f ====
rtl/avmm2_cmd_pkg.sv
rtl/avmm2_rsp_pkg.sv
rtl/avmm2_cfg.sv
rtl/avmm2_cmd_framer.sv
rtl/avmm2_cmd_fifo.sv
rtl/avmm2_cmd_serializer.sv
rtl/avmm2_rsp_deserializer.sv
rtl/avmm2_rsp_decoder.sv
rtl/avmm2_transfer.sv
test/avmm2_transfer_checker.sv
test/avmm2_transfer_tb.sv

// ==== test/avmm2_transfer_checker.sv ====
/* AVMM2 transfer checker
   Rebuilds link frames, tracks fabric outputs and grades each table entry */
module avmm2_transfer_checker
(
	input logic       clk,
	input logic [1:0] link,
	input logic       busy,
	input logic [7:0] rdata,
	input logic       rdv,
	input logic       full,
	input logic       pfull,
	input logic       err
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int K_CMD   = 0;
	localparam int K_BURST = 1;
	localparam int K_RSP   = 2;

	logic [31:0] got[$];	// Frames rebuilt since the last check
	logic [31:0] shreg;
	int          pairs;
	int          rdv_cnt;
	logic [7:0]  rdv_data;
	logic        full_seen;
	logic        pfull_seen;
	logic [12:0] snap;	// busy, rdv, rdata, full, pfull, err
	int          pass_cnt;
	int          fail_cnt;

	initial
	begin
		pairs      = 0;
		rdv_cnt    = 0;
		rdv_data   = '0;
		full_seen  = 1'b0;
		pfull_seen = 1'b0;
		pass_cnt   = 0;
		fail_cnt   = 0;
	end

	always @(negedge clk)
	begin
		if (pairs != 0 || link != 2'b00)
		begin
			shreg = {link, shreg[31:2]};	// First pair ends at the bottom
			pairs++;
			if (pairs == 16)
			begin
				got.push_back(shreg);
				pairs = 0;
			end
		end
		if (rdv)
		begin
			rdv_cnt++;
			rdv_data = rdata;
		end
		full_seen  = full_seen | full;
		pfull_seen = pfull_seen | pfull;
		snap       = {busy, rdv, rdata, full, pfull, err};
	end

	task automatic grade(string name, logic ok, string why);
		if (ok)
		begin
			pass_cnt++;
			$display("pass %s", name);
		end
		else
		begin
			fail_cnt++;
			$display("%s", why);
		end
	endtask

	always @(avmm2_transfer_tb.check_ev)
	begin : check_entry
		string       name;
		logic [31:0] exp;
		int          cnt;
		int          j;
		logic        ok;
		name = avmm2_transfer_tb.tbl[avmm2_transfer_tb.cur].name;
		exp  = avmm2_transfer_tb.tbl[avmm2_transfer_tb.cur].exp;
		cnt  = avmm2_transfer_tb.tbl[avmm2_transfer_tb.cur].exp_cnt;
		case (avmm2_transfer_tb.tbl[avmm2_transfer_tb.cur].kind)
			K_CMD:
				if (got.size() != cnt)
					grade(name, 1'b0, $sformatf("%s: %0d frames expected on the link, %0d seen",
						name, cnt, got.size()));
				else
					grade(name, cnt == 0 || got[0] === exp,
						$sformatf("error %s expected %h actual %h", name, exp, got[0]));
			K_BURST:
			begin
				j  = 0;
				ok = 1'b1;
				foreach (got[g])
				begin
					while (j < avmm2_transfer_tb.burst_exp.size() &&
						avmm2_transfer_tb.burst_exp[j] !== got[g])
						j++;
					if (j == avmm2_transfer_tb.burst_exp.size())
						ok = 1'b0;
					j++;
				end
				if (got.size() == 0 || !ok)
					grade(name, 1'b0, $sformatf("%s: frames missing or out of burst order", name));
				else if (!full_seen || !pfull_seen)
					grade(name, 1'b0, $sformatf("%s: full or partial-full never rose", name));
				else
					grade(name, snap[2:1] == 2'b00,
						$sformatf("%s: queue flags still high after the link went idle", name));
			end
			K_RSP:
				grade(name, rdv_cnt == cnt && {rdv_data, snap[12], snap[0]} === exp[9:0],
					$sformatf("error %s expected %0d/%h actual %0d/%h", name, cnt, exp[9:0],
						rdv_cnt, {rdv_data, snap[12], snap[0]}));
			default:
				grade(name, snap === exp[12:0],
					$sformatf("error %s expected %h actual %h", name, exp[12:0], snap));
		endcase
		got.delete();
		rdv_cnt    = 0;
		rdv_data   = '0;
		full_seen  = 1'b0;
		pfull_seen = 1'b0;
	end

endmodule

// ==== test/avmm2_transfer_tb.sv ====
/* AVMM2 transfer bridge testbench
   Table-driven commands, serial responses and control changes */
module avmm2_transfer_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_TESTS   = 22;
	localparam int PERIOD    = 8;
	localparam int WD_FACTOR = 60;	// Cycles allowed per table entry
	localparam int K_CMD     = 0;
	localparam int K_BURST   = 1;
	localparam int K_RSP     = 2;
	localparam int K_CTRL    = 3;
	localparam int K_RESET   = 4;

	typedef struct packed {
		logic       rd;
		logic       wr;
		logic       req;	// Request level, held after the entry
		logic [8:0] addr;
		logic [7:0] wdata;
		logic       um;
		logic       gd;
		logic       hssi;
		logic       nfrz;
		logic       rbusy;	// Response frame fields
		logic       rrdv;
		logic [7:0] rdata;
		logic       flip;
		logic       badcopy;
	} stim_t;

	typedef struct {
		string       name;
		int          kind;
		stim_t       st;
		logic [31:0] exp;
		int          exp_cnt;
	} entry_t;

	entry_t      tbl[N_TESTS];
	logic [31:0] burst_exp[$];
	event        check_ev;
	int          cur;
	int          n_built;
	integer      seed;
	logic        m_sel;	// Reference model state
	logic        m_hssi;
	logic        m_stored;
	logic        m_err;
	logic        m_gate;

	logic       clk;
	logic       rst_n;
	logic       data_in;
	logic       read;
	logic [8:0] addr;
	logic       request;
	logic       write;
	logic [7:0] wdata;
	logic       nfrz;
	logic       usermode;
	logic       hssi_busy;
	logic       gate_dis;
	logic [1:0] data_out;
	logic       busy;
	logic [7:0] rdata;
	logic       rdv;
	logic       full;
	logic       pfull;
	logic       err;

	avmm2_transfer #(
		.CMD_FIFO_DEPTH  (16),
		.CMD_PFULL_LEVEL (12)
	) dut (
		.avmm_clock_avmm_clk       (clk),
		.avmm_reset_avmm_rst_n     (rst_n),
		.aib_fabric_avmm_data_in   (data_in),
		.pld_avmm_read             (read),
		.pld_avmm_reg_addr         (addr),
		.pld_avmm_request          (request),
		.pld_avmm_write            (write),
		.pld_avmm_writedata        (wdata),
		.nfrzdrv_in                (nfrz),
		.usermode_in               (usermode),
		.sr_hssi_avmm_busy         (hssi_busy),
		.r_avmm2_gate_dis          (gate_dis),
		.aib_fabric_avmm_data_out  (data_out),
		.pld_avmm_busy             (busy),
		.pld_avmm_readdata         (rdata),
		.pld_avmm_readdatavalid    (rdv),
		.pld_avmm_cmdfifo_wr_full  (full),
		.pld_avmm_cmdfifo_wr_pfull (pfull),
		.avmm_transfer_error       (err)
	);

	avmm2_transfer_checker avmm2_transfer_checker (
		.clk   (clk),
		.link  (data_out),
		.busy  (busy),
		.rdata (rdata),
		.rdv   (rdv),
		.full  (full),
		.pfull (pfull),
		.err   (err)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Frame layouts built bit by bit from the link format
	function automatic logic [31:0] cmd_frame_of(stim_t s);
		logic [31:0] f;
		f        = 32'b0;
		f[0]     = 1'b1;
		f[1]     = s.wr;
		f[2]     = s.req;
		f[3]     = s.rd;
		f[12:4]  = s.addr;
		f[31:24] = s.wdata;
		f[23]    = ^f;
		return f;
	endfunction

	function automatic logic [15:0] rsp_frame_of(stim_t s);
		logic [15:0] f;
		f       = 16'b0;
		f[0]    = 1'b1;
		f[1]    = s.rbusy;
		f[9:2]  = s.rdata;
		f[10]   = s.rrdv;
		f[15]   = ~s.badcopy;
		f[14]   = (^f) ^ s.flip;
		return f;
	endfunction

	function automatic stim_t cmd_stim(logic rd, logic wr, logic req);
		stim_t s;
		s       = '0;
		s.rd    = rd;
		s.wr    = wr;
		s.req   = req;
		s.addr  = $random(seed);
		s.wdata = $random(seed);
		return s;
	endfunction

	function automatic stim_t ctrl_stim(logic um, logic gd, logic hb, logic nf);
		stim_t s;
		s      = '0;
		s.um   = um;
		s.gd   = gd;
		s.hssi = hb;
		s.nfrz = nf;
		return s;
	endfunction

	function automatic stim_t rsp_stim(logic rb, logic rv, logic fl, logic bc);
		stim_t s;
		s         = '0;
		s.rbusy   = rb;
		s.rrdv    = rv;
		s.rdata   = $random(seed);
		s.flip    = fl;
		s.badcopy = bc;
		return s;
	endfunction

	task automatic add_entry(string n, int k, stim_t s);
		tbl[n_built].name = n;
		tbl[n_built].kind = k;
		tbl[n_built].st   = s;
		n_built++;
	endtask

	task automatic drive_cmd(stim_t s);
		@(negedge clk);
		read    = s.rd;
		write   = s.wr;
		request = s.req;
		addr    = s.addr;
		wdata   = s.wdata;
		@(negedge clk);
		read  = 1'b0;
		write = 1'b0;
	endtask

	task automatic run_burst();
		stim_t s;
		for (int b = 0; b < 40; b++)
		begin
			s = cmd_stim(1'b0, 1'b1, 1'b0);
			@(negedge clk);
			write = 1'b1;
			addr  = s.addr;
			wdata = s.wdata;
			burst_exp.push_back(cmd_frame_of(s));
		end
		@(negedge clk);
		write = 1'b0;
	endtask

	// A frame never holds 17 zero pairs in a row
	task automatic wait_link_idle();
		int quiet;
		quiet = 0;
		while (quiet < 17)
		begin
			@(negedge clk);
			if (data_out == 2'b00)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic send_rsp(logic [15:0] f);
		for (int b = 0; b < 16; b++)
		begin
			@(negedge clk);
			data_in = f[b];	// Lowest bit first
		end
		@(negedge clk);
		data_in = 1'b0;
		repeat (6) @(negedge clk);
	endtask

	initial
	begin : watchdog
		#(N_TESTS * WD_FACTOR * PERIOD);
		$display("timeout: the table did not finish in the allowed time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin : main
		logic [15:0] f;
		logic        pulse;
		seed = 38716;
		clk = 1'b0;
		rst_n = 1'b0;
		data_in = 1'b0;
		read = 1'b0;
		addr = '0;
		request = 1'b0;
		write = 1'b0;
		wdata = '0;
		nfrz = 1'b1;
		usermode = 1'b1;
		hssi_busy = 1'b1;
		gate_dis = 1'b0;
		m_sel = 1'b1;
		m_hssi = 1'b1;
		m_stored = 1'b0;
		m_err = 1'b0;
		m_gate = 1'b1;
		n_built = 0;

		add_entry("reset_state", K_CTRL, ctrl_stim(1'b1, 1'b0, 1'b1, 1'b1));
		add_entry("write_a", K_CMD, cmd_stim(1'b0, 1'b1, 1'b0));
		add_entry("read_b", K_CMD, cmd_stim(1'b1, 1'b0, 1'b0));
		add_entry("req_rise", K_CMD, cmd_stim(1'b0, 1'b0, 1'b1));
		add_entry("write_req_hi", K_CMD, cmd_stim(1'b0, 1'b1, 1'b1));
		add_entry("req_fall", K_CMD, cmd_stim(1'b0, 1'b0, 1'b0));
		add_entry("gate_closed", K_CTRL, ctrl_stim(1'b0, 1'b0, 1'b1, 1'b1));
		add_entry("write_gated", K_CMD, cmd_stim(1'b0, 1'b1, 1'b0));
		add_entry("read_gated", K_CMD, cmd_stim(1'b1, 1'b0, 1'b0));
		add_entry("gate_disable", K_CTRL, ctrl_stim(1'b0, 1'b1, 1'b1, 1'b1));
		add_entry("write_bypass", K_CMD, cmd_stim(1'b0, 1'b1, 1'b0));
		add_entry("burst_40", K_BURST, '0);
		add_entry("hssi_busy_low", K_CTRL, ctrl_stim(1'b1, 1'b0, 1'b0, 1'b1));
		add_entry("rsp_busy", K_RSP, rsp_stim(1'b1, 1'b1, 1'b0, 1'b0));
		add_entry("rsp_after_busy", K_RSP, rsp_stim(1'b0, 1'b1, 1'b0, 1'b0));
		add_entry("hssi_busy_high", K_CTRL, ctrl_stim(1'b1, 1'b0, 1'b1, 1'b1));
		add_entry("rsp_read_ok", K_RSP, rsp_stim(1'b0, 1'b1, 1'b0, 1'b0));
		add_entry("rsp_busy_set", K_RSP, rsp_stim(1'b1, 1'b1, 1'b0, 1'b0));
		add_entry("rsp_parity_bad", K_RSP, rsp_stim(1'b0, 1'b0, 1'b1, 1'b0));
		add_entry("freeze", K_CTRL, ctrl_stim(1'b1, 1'b0, 1'b1, 1'b0));
		add_entry("reset_unfreeze", K_RESET, '0);
		add_entry("rsp_copy_bad", K_RSP, rsp_stim(1'b0, 1'b0, 1'b0, 1'b1));

		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);

		for (int i = 0; i < N_TESTS; i++)
		begin
			cur = i;
			case (tbl[i].kind)
				K_CMD:
				begin
					tbl[i].exp     = cmd_frame_of(tbl[i].st);
					tbl[i].exp_cnt = m_gate;
					drive_cmd(tbl[i].st);
					wait_link_idle();
				end
				K_BURST:
				begin
					run_burst();
					wait_link_idle();
				end
				K_RSP:
				begin
					@(negedge clk);
					f        = rsp_frame_of(tbl[i].st);
					pulse    = !f[1] && !m_stored && f[10];
					m_stored = f[1];
					if ((^f) || (f[0] != f[15]))
						m_err = 1'b1;
					tbl[i].exp_cnt = pulse;
					tbl[i].exp = {22'b0, pulse ? f[9:2] : 8'h00,
						m_sel ? m_hssi : m_stored, m_err};
					send_rsp(f);
				end
				K_RESET:
				begin
					@(negedge clk);
					nfrz  = 1'b1;
					rst_n = 1'b0;
					repeat (8) @(negedge clk);
					rst_n    = 1'b1;
					m_sel    = 1'b1;	// Hand-over and error flag start over
					m_stored = 1'b0;
					m_err    = 1'b0;
					tbl[i].exp = {19'b0, m_hssi, 11'h000, m_err};
					repeat (4) @(negedge clk);
				end
				default:
				begin
					@(negedge clk);
					usermode  = tbl[i].st.um;
					gate_dis  = tbl[i].st.gd;
					hssi_busy = tbl[i].st.hssi;
					nfrz      = tbl[i].st.nfrz;
					m_gate    = tbl[i].st.um | tbl[i].st.gd;
					m_hssi    = tbl[i].st.hssi;
					if (!tbl[i].st.hssi)
						m_sel = 1'b0;	// Hand-over is permanent
					if (tbl[i].st.nfrz)
						tbl[i].exp = {19'b0, m_sel ? m_hssi : m_stored, 11'h000, m_err};
					else
						tbl[i].exp = {19'b0, 12'hFFF, m_err};
					repeat (5) @(negedge clk);
				end
			endcase
			@(posedge clk);
			-> check_ev;
			@(negedge clk);
		end
		@(negedge clk);

		$display("closing: %0d passed, %0d failed", avmm2_transfer_checker.pass_cnt,
			avmm2_transfer_checker.fail_cnt);
		if (avmm2_transfer_checker.fail_cnt == 0 && avmm2_transfer_checker.pass_cnt == N_TESTS)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
